// ==== src/rv32i_consts.svh ====
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// major opcodes, instr[6:0].
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111

// funct3 of the integer alu group.
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

`endif

// ==== src/rv32i_types.sv ====
`include "rv32i_consts.svh"

package rv32i_types;

    typedef enum logic [6:0] {
        opc_op     = `OPC_OP,
        opc_op_imm = `OPC_OP_IMM,
        opc_lui    = `OPC_LUI,
        opc_auipc  = `OPC_AUIPC
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10  // lui result.
    } alu_op_e;

    typedef enum logic {
        opa_rs1 = 1'b0,
        opa_pc  = 1'b1
    } opa_sel_e;

    typedef enum logic [1:0] {
        opb_rs2   = 2'd0,
        opb_i_imm = 2'd1,
        opb_u_imm = 2'd2
    } opb_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        opa_sel_e opa_sel;
        opb_sel_e opb_sel;
        logic     reg_write;
        logic     valid;      // zero marks a bubble.
        opcode_e  opcode;
    } rv32i_control_word;

endpackage

// ==== src/instr_decoder.sv ====
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module instr_decoder import rv32i_types::*; (
    input  logic [`XLEN-1:0] instr_i,
    input  logic             instr_valid_i,
    output rv32i_control_word ctrl_o,
    output logic             illegal_o
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              legal;
    rv32i_control_word ctrl;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            `F3_ADD:  op = alt ? alu_sub : alu_add;
            `F3_SLL:  op = alu_sll;
            `F3_SLT:  op = alu_slt;
            `F3_SLTU: op = alu_sltu;
            `F3_XOR:  op = alu_xor;
            `F3_SR:   op = alt ? alu_sra : alu_srl;
            `F3_OR:   op = alu_or;
            default:  op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl  = '0;
        legal = 1'b0;
        case (opcode)
            `OPC_OP: begin
                ctrl.opcode = opc_op;
                ctrl.alu_op = f3_to_alu(funct3, funct7[5]);
                legal = (funct7 == `F7_BASE) ||
                        ((funct7 == `F7_ALT) && (funct3 == `F3_ADD || funct3 == `F3_SR));
            end
            `OPC_OP_IMM: begin
                ctrl.opcode  = opc_op_imm;
                ctrl.opb_sel = opb_i_imm;
                // only srai carries the alternate bit; addi never becomes sub.
                ctrl.alu_op  = f3_to_alu(funct3, (funct3 == `F3_SR) && funct7[5]);
                if (funct3 == `F3_SLL) begin
                    legal = (funct7 == `F7_BASE);
                end else if (funct3 == `F3_SR) begin
                    legal = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
                end else begin
                    legal = 1'b1;
                end
            end
            `OPC_LUI: begin
                ctrl.opcode  = opc_lui;
                ctrl.opb_sel = opb_u_imm;
                ctrl.alu_op  = alu_pass_b;
                legal = 1'b1;
            end
            `OPC_AUIPC: begin
                ctrl.opcode  = opc_auipc;
                ctrl.opa_sel = opa_pc;
                ctrl.opb_sel = opb_u_imm;
                ctrl.alu_op  = alu_add;
                legal = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        ctrl.valid     = 1'b1;
        ctrl.reg_write = 1'b1;
    end

    assign ctrl_o    = (instr_valid_i && legal) ? ctrl : '0;  // bubble otherwise.
    assign illegal_o = instr_valid_i && !legal;

    always_comb begin
        assert (!(illegal_o && ctrl_o.reg_write))
            else $error("illegal instruction decoded with reg_write set");
    end

endmodule

// ==== src/imm_gen.sv ====
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module imm_gen (
    input  logic [`XLEN-1:0] instr_i,
    output logic [`XLEN-1:0] i_imm_o,
    output logic [`XLEN-1:0] s_imm_o,
    output logic [`XLEN-1:0] b_imm_o,
    output logic [`XLEN-1:0] u_imm_o,
    output logic [`XLEN-1:0] j_imm_o
);

    logic sign;

    assign sign = instr_i[31];

    assign i_imm_o = {{21{sign}}, instr_i[30:20]};

    assign s_imm_o = {{21{sign}}, instr_i[30:25], instr_i[11:7]};

    // branch offsets are even, bit 0 is implied.
    assign b_imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    assign u_imm_o = {instr_i[31:12], 12'h000};

    assign j_imm_o = {
        {12{sign}},
        instr_i[19:12],
        instr_i[20],
        instr_i[30:21],
        1'b0
    };

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [`REG_ADDR_W-1:0] rd_addr_i,
    input  logic                   we_i,
    input  logic [`XLEN-1:0]       rd_data_i,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_addr_i != '0)) begin  // x0 drops writes.
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // same-cycle write is forwarded to the readers.
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                        (we_i && (rd_addr_i == rs1_addr_i)) ? rd_data_i :
                        regs[rs1_addr_i];

    assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                        (we_i && (rd_addr_i == rs2_addr_i)) ? rd_data_i :
                        regs[rs2_addr_i];

    // x0 storage stays zero across every write-back.
    assert property (@(posedge clk) disable iff (rst) (regs[0] == '0))
        else $error("x0 read back nonzero");

endmodule

// ==== src/id_ex.sv ====
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module id_ex import rv32i_types::*; #(
    parameter int width = `XLEN
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_i,
    input  rv32i_control_word      ctrl_word_i,
    input  logic [width-1:0]       instr_i,
    input  logic [width-1:0]       pc_i,
    input  logic [width-1:0]       rs1_i,
    input  logic [width-1:0]       rs2_i,
    input  logic [width-1:0]       i_imm_i,
    input  logic [width-1:0]       s_imm_i,
    input  logic [width-1:0]       b_imm_i,
    input  logic [width-1:0]       u_imm_i,
    input  logic [width-1:0]       j_imm_i,
    input  logic [`REG_ADDR_W-1:0] rd_i,
    output rv32i_control_word      ctrl_word_o,
    output logic [width-1:0]       instr_o,
    output logic [width-1:0]       pc_o,
    output logic [width-1:0]       rs1_o,
    output logic [width-1:0]       rs2_o,
    output logic [width-1:0]       i_imm_o,
    output logic [width-1:0]       s_imm_o,
    output logic [width-1:0]       b_imm_o,
    output logic [width-1:0]       u_imm_o,
    output logic [width-1:0]       j_imm_o,
    output logic [`REG_ADDR_W-1:0] rd_o
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_word_o <= '0;
            instr_o     <= '0;
            pc_o        <= '0;
            rs1_o       <= '0;
            rs2_o       <= '0;
            i_imm_o     <= '0;
            s_imm_o     <= '0;
            b_imm_o     <= '0;
            u_imm_o     <= '0;
            j_imm_o     <= '0;
            rd_o        <= '0;
        end else if (load_i) begin
            ctrl_word_o <= ctrl_word_i;  // zero word from decode is a bubble.
            instr_o     <= instr_i;
            pc_o        <= pc_i;
            rs1_o       <= rs1_i;
            rs2_o       <= rs2_i;
            i_imm_o     <= i_imm_i;
            s_imm_o     <= s_imm_i;
            b_imm_o     <= b_imm_i;
            u_imm_o     <= u_imm_i;
            j_imm_o     <= j_imm_i;
            rd_o        <= rd_i;
        end
    end

    // a stalled stage keeps its instruction for the later write-back.
    assert property (@(posedge clk) (!rst && !load_i) |=>
        $stable(ctrl_word_o) && $stable(instr_o) && $stable(pc_o) &&
        $stable(rs1_o) && $stable(rs2_o) && $stable(i_imm_o) &&
        $stable(s_imm_o) && $stable(b_imm_o) && $stable(u_imm_o) &&
        $stable(j_imm_o) && $stable(rd_o))
        else $error("id/ex contents changed while held");

endmodule

// ==== src/alu_exec.sv ====
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module alu_exec import rv32i_types::*; (
    input  rv32i_control_word ctrl_i,
    input  logic [`XLEN-1:0]  pc_i,
    input  logic [`XLEN-1:0]  rs1_i,
    input  logic [`XLEN-1:0]  rs2_i,
    input  logic [`XLEN-1:0]  i_imm_i,
    input  logic [`XLEN-1:0]  u_imm_i,
    output logic [`XLEN-1:0]  result_o
);

    logic [`XLEN-1:0] opa;
    logic [`XLEN-1:0] opb;
    logic [4:0]       shamt;

    assign opa = (ctrl_i.opa_sel == opa_pc) ? pc_i : rs1_i;

    always_comb begin
        case (ctrl_i.opb_sel)
            opb_i_imm: opb = i_imm_i;
            opb_u_imm: opb = u_imm_i;
            default:   opb = rs2_i;
        endcase
    end

    assign shamt = opb[4:0];  // shift amount, low five bits.

    always_comb begin
        case (ctrl_i.alu_op)
            alu_add:    result_o = opa + opb;
            alu_sub:    result_o = opa - opb;
            alu_sll:    result_o = opa << shamt;
            alu_slt:    result_o = `XLEN'($signed(opa) < $signed(opb));
            alu_sltu:   result_o = `XLEN'(opa < opb);
            alu_xor:    result_o = opa ^ opb;
            alu_srl:    result_o = opa >> shamt;
            alu_sra:    result_o = $unsigned($signed(opa) >>> shamt);  // sign fill.
            alu_or:     result_o = opa | opb;
            alu_and:    result_o = opa & opb;
            alu_pass_b: result_o = opb;
            default:    result_o = '0;
        endcase
    end

endmodule

// ==== src/dec_exec_core.sv ====
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module dec_exec_core import rv32i_types::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`XLEN-1:0]       instr_i,
    input  logic [`XLEN-1:0]       pc_i,
    input  logic                   instr_valid_i,
    input  logic                   stall_i,
    output logic                   illegal_o,
    output logic                   wb_valid_o,
    output logic [`REG_ADDR_W-1:0] wb_rd_o,
    output logic [`XLEN-1:0]       wb_data_o
);

    rv32i_control_word id_ctrl;
    rv32i_control_word ex_ctrl;
    logic [`XLEN-1:0]  id_rs1, id_rs2;
    logic [`XLEN-1:0]  id_i_imm, id_s_imm, id_b_imm, id_u_imm, id_j_imm;
    logic [`XLEN-1:0]  ex_pc, ex_rs1, ex_rs2, ex_i_imm, ex_u_imm;
    logic              id_ex_load;

    assign id_ex_load = !stall_i;

    instr_decoder u_decoder (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .ctrl_o        (id_ctrl),
        .illegal_o     (illegal_o)
    );

    imm_gen u_imm_gen (
        .instr_i (instr_i),
        .i_imm_o (id_i_imm),
        .s_imm_o (id_s_imm),
        .b_imm_o (id_b_imm),
        .u_imm_o (id_u_imm),
        .j_imm_o (id_j_imm)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr_i (instr_i[19:15]),
        .rs2_addr_i (instr_i[24:20]),
        .rd_addr_i  (wb_rd_o),
        .we_i       (wb_valid_o),
        .rd_data_i  (wb_data_o),
        .rs1_data_o (id_rs1),
        .rs2_data_o (id_rs2)
    );

    // s, b and j immediates and the raw instruction ride along unused.
    id_ex #(.width(`XLEN)) u_id_ex (
        .clk (clk), .rst (rst), .load_i (id_ex_load),
        .ctrl_word_i (id_ctrl),  .ctrl_word_o (ex_ctrl),
        .instr_i     (instr_i),  .instr_o     (),
        .pc_i        (pc_i),     .pc_o        (ex_pc),
        .rs1_i       (id_rs1),   .rs1_o       (ex_rs1),
        .rs2_i       (id_rs2),   .rs2_o       (ex_rs2),
        .i_imm_i     (id_i_imm), .i_imm_o     (ex_i_imm),
        .s_imm_i     (id_s_imm), .s_imm_o     (),
        .b_imm_i     (id_b_imm), .b_imm_o     (),
        .u_imm_i     (id_u_imm), .u_imm_o     (ex_u_imm),
        .j_imm_i     (id_j_imm), .j_imm_o     (),
        .rd_i        (instr_i[11:7]), .rd_o   (wb_rd_o)
    );

    alu_exec u_alu_exec (
        .ctrl_i   (ex_ctrl),
        .pc_i     (ex_pc),
        .rs1_i    (ex_rs1),
        .rs2_i    (ex_rs2),
        .i_imm_i  (ex_i_imm),
        .u_imm_i  (ex_u_imm),
        .result_o (wb_data_o)
    );

    assign wb_valid_o = ex_ctrl.valid && ex_ctrl.reg_write && !stall_i;  // held while stalled.

endmodule

// ==== tests/tb_dec_exec_core.sv ====
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module tb_dec_exec_core;

    typedef struct {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        valid;
        logic        stall;
        logic        exp_illegal;
        logic        exp_wb_valid;
        logic [4:0]  exp_wb_rd;
        logic [31:0] exp_wb_data;
    } entry_t;

    logic        clk;
    logic        rst;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        instr_valid_i;
    logic        stall_i;
    logic        illegal_o;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;

    entry_t      vectors_q[$];
    logic        vectors_ready;
    logic [31:0] ref_regs [32];
    logic        pend_valid;   // model of the id/ex stage.
    logic [4:0]  pend_rd;
    logic [31:0] pend_data;
    int          errors;
    int          checks;

    dec_exec_core i_dut (
        .clk           (clk),
        .rst           (rst),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .instr_valid_i (instr_valid_i),
        .stall_i       (stall_i),
        .illegal_o     (illegal_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [19:0] imm,
                                          input logic [4:0] rd);
        return {imm, rd, opc};
    endfunction

    // result of one instruction by the rv32i rules, on the model registers.
    task automatic isa_result(input logic [31:0] instr, input logic [31:0] pc,
                              output logic legal, output logic [31:0] res);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_u;
        logic        alt;
        opc   = instr[6:0];
        f3    = instr[14:12];
        f7    = instr[31:25];
        a     = ref_regs[instr[19:15]];
        imm_u = {instr[31:12], 12'h000};
        b     = (opc == `OPC_OP) ? ref_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
        alt   = f7[5] && ((opc == `OPC_OP) || (f3 == 3'd5));  // addi has no sub form.
        legal = 1'b1;
        res   = 32'h0;
        case (opc)
            `OPC_OP: legal = (f7 == `F7_BASE) ||
                             ((f7 == `F7_ALT) && ((f3 == 3'd0) || (f3 == 3'd5)));
            `OPC_OP_IMM: begin
                if (f3 == 3'd1) legal = (f7 == `F7_BASE);
                else if (f3 == 3'd5) legal = (f7 == `F7_BASE) || (f7 == `F7_ALT);
            end
            `OPC_LUI:   res = imm_u;
            `OPC_AUIPC: res = pc + imm_u;
            default:    legal = 1'b0;
        endcase
        if ((opc == `OPC_OP) || (opc == `OPC_OP_IMM)) begin
            case (f3)
                3'd0: res = alt ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = {31'h0, $signed(a) < $signed(b)};
                3'd3: res = {31'h0, a < b};
                3'd4: res = a ^ b;
                3'd5: res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end
    endtask

    // one cycle of stimulus; expected outputs are those seen in that same cycle.
    task automatic add_entry(input logic [31:0] instr, input logic valid, input logic stall);
        entry_t      e;
        logic        legal;
        logic [31:0] res;
        e.instr        = instr;
        e.pc           = 32'h0000_1000 + 32'(vectors_q.size()) * 32'd4;
        e.valid        = valid;
        e.stall        = stall;
        e.exp_wb_valid = pend_valid && !stall;
        e.exp_wb_rd    = pend_rd;
        e.exp_wb_data  = pend_data;
        if (e.exp_wb_valid && (pend_rd != 5'd0)) ref_regs[pend_rd] = pend_data;  // bypass.
        isa_result(instr, e.pc, legal, res);
        e.exp_illegal = valid && !legal;
        if (!stall) begin
            pend_valid = valid && legal;
            pend_rd    = instr[11:7];
            pend_data  = res;
        end
        vectors_q.push_back(e);
    endtask

    task automatic build_vectors();
        for (int r = 1; r <= 6; r++) begin
            add_entry(enc_i(12'($urandom()), 5'd0, `F3_ADD, 5'(r)), 1'b1, 1'b0);
        end
        add_entry(enc_i(12'hffb, 5'd0, `F3_ADD, 5'd7), 1'b1, 1'b0);  // x7 = -5.
        add_entry(enc_u(`OPC_LUI, 20'h80000, 5'd8), 1'b1, 1'b0);
        add_entry(enc_r(`F7_BASE, 5'd2, 5'd1, `F3_ADD, 5'd10), 1'b1, 1'b0);
        add_entry(enc_r(`F7_ALT, 5'd7, 5'd1, `F3_ADD, 5'd11), 1'b1, 1'b0);
        add_entry(enc_r(`F7_BASE, 5'd2, 5'd1, `F3_SLL, 5'd12), 1'b1, 1'b0);
        add_entry(enc_r(`F7_BASE, 5'd0, 5'd7, `F3_SLT, 5'd13), 1'b1, 1'b0);
        add_entry(enc_r(`F7_BASE, 5'd0, 5'd7, `F3_SLTU, 5'd14), 1'b1, 1'b0);
        add_entry(enc_r(`F7_BASE, 5'd2, 5'd1, `F3_XOR, 5'd15), 1'b1, 1'b0);
        add_entry(enc_r(`F7_BASE, 5'd7, 5'd8, `F3_SR, 5'd16), 1'b1, 1'b0);
        add_entry(enc_r(`F7_ALT, 5'd7, 5'd8, `F3_SR, 5'd17), 1'b1, 1'b0);
        add_entry(enc_r(`F7_BASE, 5'd2, 5'd1, `F3_OR, 5'd18), 1'b1, 1'b0);
        add_entry(enc_r(`F7_BASE, 5'd2, 5'd1, `F3_AND, 5'd19), 1'b1, 1'b0);
        add_entry(enc_i(12'hf9c, 5'd1, `F3_ADD, 5'd20), 1'b1, 1'b0);
        add_entry(enc_i(12'h003, 5'd7, `F3_SLT, 5'd21), 1'b1, 1'b0);
        add_entry(enc_i(12'hfff, 5'd1, `F3_SLTU, 5'd22), 1'b1, 1'b0);
        add_entry(enc_i(12'hfff, 5'd2, `F3_XOR, 5'd23), 1'b1, 1'b0);
        add_entry(enc_i(12'h0f0, 5'd2, `F3_OR, 5'd24), 1'b1, 1'b0);
        add_entry(enc_i(12'h8f0, 5'd1, `F3_AND, 5'd25), 1'b1, 1'b0);
        add_entry(enc_i(12'h007, 5'd1, `F3_SLL, 5'd26), 1'b1, 1'b0);
        add_entry(enc_i(12'h004, 5'd8, `F3_SR, 5'd27), 1'b1, 1'b0);
        add_entry(enc_i(12'h404, 5'd8, `F3_SR, 5'd28), 1'b1, 1'b0);   // srai.
        add_entry(enc_u(`OPC_LUI, 20'habcde, 5'd29), 1'b1, 1'b0);
        add_entry(enc_u(`OPC_AUIPC, 20'h00012, 5'd30), 1'b1, 1'b0);
        add_entry(enc_i(12'h00a, 5'd0, `F3_ADD, 5'd5), 1'b1, 1'b0);
        add_entry(enc_r(`F7_BASE, 5'd5, 5'd5, `F3_ADD, 5'd5), 1'b1, 1'b0);
        add_entry(enc_r(`F7_BASE, 5'd5, 5'd5, `F3_ADD, 5'd6), 1'b1, 1'b0);
        add_entry(enc_i(12'h037, 5'd1, `F3_ADD, 5'd0), 1'b1, 1'b0);   // write to x0.
        add_entry(enc_r(`F7_BASE, 5'd0, 5'd0, `F3_OR, 5'd9), 1'b1, 1'b0);
        add_entry(enc_i(12'h001, 5'd3, `F3_ADD, 5'd3), 1'b1, 1'b0);
        add_entry(enc_r(`F7_BASE, 5'd1, 5'd1, `F3_ADD, 5'd9), 1'b1, 1'b1);
        add_entry(enc_r(`F7_BASE, 5'd2, 5'd2, `F3_ADD, 5'd9), 1'b1, 1'b1);
        add_entry(enc_r(`F7_BASE, 5'd3, 5'd3, `F3_ADD, 5'd4), 1'b1, 1'b0);
        add_entry(enc_i(12'h123, 5'd4, `F3_ADD, 5'd12), 1'b0, 1'b0);  // not valid.
        add_entry(enc_r(`F7_ALT, 5'd2, 5'd1, `F3_SLL, 5'd13), 1'b1, 1'b0);
        add_entry(enc_i(12'h401, 5'd1, `F3_SLL, 5'd14), 1'b1, 1'b0);
        add_entry({25'h0, 7'b0000011}, 1'b1, 1'b0);                  // load opcode.
        add_entry(enc_r(`F7_BASE, 5'd14, 5'd13, `F3_XOR, 5'd15), 1'b1, 1'b0);
        add_entry(enc_r(`F7_BASE, 5'd4, 5'd12, `F3_ADD, 5'd16), 1'b1, 1'b0);
        add_entry(32'h0, 1'b0, 1'b0);  // drain.
    endtask

    task automatic check_outputs(input int idx, input entry_t e);
        checks++;
        assert (illegal_o === e.exp_illegal) else begin
            errors++;
            $display("[FAIL] %0t: entry %0d illegal_o %b, expected %b",
                     $time, idx, illegal_o, e.exp_illegal);
        end
        assert (wb_valid_o === e.exp_wb_valid) else begin
            errors++;
            $display("[FAIL] %0t: entry %0d wb_valid_o %b, expected %b",
                     $time, idx, wb_valid_o, e.exp_wb_valid);
        end
        if (e.exp_wb_valid) begin
            assert ((wb_rd_o === e.exp_wb_rd) && (wb_data_o === e.exp_wb_data)) else begin
                errors++;
                $display("[FAIL] %0t: entry %0d write-back x%0d = %h, expected x%0d = %h",
                         $time, idx, wb_rd_o, wb_data_o, e.exp_wb_rd, e.exp_wb_data);
            end
        end
    endtask

    initial begin
        void'($urandom(32'hf873_76f8));
        rst           = 1'b1;
        instr_i       = 32'h0;
        pc_i          = 32'h0;
        instr_valid_i = 1'b0;
        stall_i       = 1'b0;
        vectors_ready = 1'b0;
        pend_valid    = 1'b0;
        pend_rd       = 5'd0;
        pend_data     = 32'h0;
        errors        = 0;
        checks        = 0;
        for (int r = 0; r < 32; r++) ref_regs[r] = 32'h0;
        build_vectors();
        vectors_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        foreach (vectors_q[i]) begin
            instr_i       = vectors_q[i].instr;
            pc_i          = vectors_q[i].pc;
            instr_valid_i = vectors_q[i].valid;
            stall_i       = vectors_q[i].stall;
            #4 check_outputs(i, vectors_q[i]);  // outputs have settled by mid-cycle.
            @(posedge clk);
            #1;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (vectors_ready);
        #((vectors_q.size() + 20) * 8);
        $display("timeout: the test table did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+src
src/rv32i_types.sv
src/instr_decoder.sv
src/imm_gen.sv
src/reg_file.sv
src/id_ex.sv
src/alu_exec.sv
src/dec_exec_core.sv
tests/tb_dec_exec_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_dec_exec_core
out=$(./obj_dir/Vtb_dec_exec_core)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
